/* Makefile */
VERILATOR  ?= verilator
TOP        := tbMipsCpu
FILELIST   := sources.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert
BUILD_DIR  := obj_dir
PASS_TEXT  := === PASS ===

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# The run fails unless the testbench output holds the pass line
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* design/alu.sv */
`timescale 1ns/10ps

module alu import cpuPkg::*; (
    input  aluOp_t     op,
    input  word_t      operandA,
    input  word_t      operandB,
    input  logic [4:0] shiftAmount,
    output word_t      result,
    output logic       equal
);

    logic lessSigned;
    logic lessUnsigned;

    assign lessSigned   = $signed(operandA) < $signed(operandB);
    assign lessUnsigned = operandA < operandB;

    always_comb begin
        case (op)
            ALU_ADD:  result = operandA + operandB;
            ALU_SUB:  result = operandA - operandB;
            ALU_AND:  result = operandA & operandB;
            ALU_OR:   result = operandA | operandB;
            ALU_XOR:  result = operandA ^ operandB;
            ALU_SLT:  result = {31'b0, lessSigned};
            ALU_SLTU: result = {31'b0, lessUnsigned};
            // Shifts act on rt, which arrives as operand B
            ALU_SLL:  result = operandB << shiftAmount;
            ALU_SRL:  result = operandB >> shiftAmount;
            ALU_SRA:  result = word_t'($signed(operandB) >>> shiftAmount);
            ALU_LUI:  result = {operandB[15:0], 16'h0000};
            default:  result = operandB;
        endcase
    end

    // Branch compare of rs against rt
    assign equal = operandA == operandB;

endmodule

/* design/busArbiter.sv */
`timescale 1ns/10ps

module busArbiter import cpuPkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       waitrequest,
    input  logic       fetchReqValid,
    input  word_t      fetchReqAddress,
    output logic       fetchReqReady,
    input  logic       lsuReqValid,
    input  logic       lsuReqWrite,
    input  word_t      lsuReqAddress,
    input  word_t      lsuReqWriteData,
    output logic       lsuReqReady,
    output word_t      address,
    output logic       read,
    output logic       write,
    output word_t      writedata,
    output logic [3:0] byteenable
);

    // Grant stays locked while a transfer is stalled
    logic grantActive;
    logic grantLsu;
    logic selLsu;

    // Fetch has priority unless the LSU already holds the bus
    assign selLsu = grantActive ? grantLsu : !fetchReqValid;

    assign address    = selLsu ? lsuReqAddress : fetchReqAddress;
    assign read       = selLsu ? (lsuReqValid && !lsuReqWrite) : fetchReqValid;
    assign write      = selLsu && lsuReqValid && lsuReqWrite;
    assign writedata  = lsuReqWriteData;
    // Word accesses only
    assign byteenable = 4'b1111;

    assign fetchReqReady = !selLsu && fetchReqValid && !waitrequest;
    assign lsuReqReady   = selLsu && lsuReqValid && !waitrequest;

    always_ff @(posedge clk) begin
        if (reset) begin
            grantActive <= 1'b0;
            grantLsu    <= 1'b0;
        end else if ((read || write) && waitrequest) begin
            grantActive <= 1'b1;
            grantLsu    <= selLsu;
        end else if (!waitrequest) begin
            grantActive <= 1'b0;
        end
    end

    // A stalled transfer keeps its command, address and data on the bus
    assert property (@(posedge clk) disable iff (reset)
        ((read || write) && waitrequest) |=>
            ($stable(address) && $stable(read) && $stable(write) &&
             (!write || $stable(writedata))));

endmodule

/* design/cpuControl.sv */
`timescale 1ns/10ps
`include "cpu_consts.svh"

module cpuControl import cpuPkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       fetchReady,
    input  logic       instrValid,
    input  word_t      instr,
    input  logic       memReady,
    input  logic       memDone,
    input  word_t      memReadData,
    input  word_t      readDataA,
    input  word_t      readDataB,
    input  word_t      aluResult,
    input  logic       aluEqual,
    output logic       fetchValid,
    output word_t      fetchAddress,
    output logic       memValid,
    output logic       memWrite,
    output word_t      memAddress,
    output word_t      memWriteData,
    output regAddr_t   readAddrA,
    output regAddr_t   readAddrB,
    output logic       regWriteEnable,
    output regAddr_t   regWriteAddr,
    output word_t      regWriteData,
    output aluOp_t     aluOp,
    output word_t      aluOperandA,
    output word_t      aluOperandB,
    output logic [4:0] aluShift,
    output logic       active
);

    cpuState_t state;
    word_t     ir;
    // Address of the next fetch, already past the current instruction
    word_t     pc;
    word_t     target;
    logic      redirect;
    logic      fetchIssued;
    logic      memIssued;
    word_t     immExt;
    logic      useImm;
    aluOp_t    decodedOp;
    logic [5:0] opcode;
    logic [5:0] funct;
    logic      isLoad;
    logic      isStore;
    logic      isBranch;
    logic      isJump;
    logic      takeBranch;
    logic      zeroExtImm;

    assign opcode     = ir[31:26];
    assign funct      = ir[5:0];
    assign isLoad     = opcode == `CPU_OP_LW;
    assign isStore    = opcode == `CPU_OP_SW;
    assign isBranch   = (opcode == `CPU_OP_BEQ) || (opcode == `CPU_OP_BNE);
    assign isJump     = (opcode == `CPU_OP_J) ||
                        ((opcode == `CPU_OP_SPECIAL) && (funct == `CPU_FN_JR));
    assign takeBranch = ((opcode == `CPU_OP_BEQ) && aluEqual) ||
                        ((opcode == `CPU_OP_BNE) && !aluEqual);
    assign zeroExtImm = opcode inside {`CPU_OP_ANDI, `CPU_OP_ORI, `CPU_OP_XORI};

    assign active       = state != S_HALT;
    // A jump to zero lands here after its delay slot and stops fetching
    assign fetchValid   = (state == S_FETCH) && !fetchIssued && (pc != '0);
    assign fetchAddress = pc;
    assign memValid     = (state == S_MEMORY) && !memIssued;

    assign readAddrA   = ir[25:21];
    assign readAddrB   = ir[20:16];
    assign aluOperandA = readDataA;
    assign aluOperandB = useImm ? immExt : readDataB;
    assign aluShift    = ir[10:6];

    // R-type writes rd, I-type writes rt
    assign regWriteEnable = state == S_WRITEBACK;
    assign regWriteAddr   = (opcode == `CPU_OP_SPECIAL) ? ir[15:11] : ir[20:16];
    assign regWriteData   = isLoad ? memReadData : aluResult;

    always_comb begin
        decodedOp = ALU_PASS;
        case (opcode)
            `CPU_OP_SPECIAL: begin
                case (funct)
                    `CPU_FN_ADDU: decodedOp = ALU_ADD;
                    `CPU_FN_SUBU: decodedOp = ALU_SUB;
                    `CPU_FN_AND:  decodedOp = ALU_AND;
                    `CPU_FN_OR:   decodedOp = ALU_OR;
                    `CPU_FN_XOR:  decodedOp = ALU_XOR;
                    `CPU_FN_SLT:  decodedOp = ALU_SLT;
                    `CPU_FN_SLTU: decodedOp = ALU_SLTU;
                    `CPU_FN_SLL:  decodedOp = ALU_SLL;
                    `CPU_FN_SRL:  decodedOp = ALU_SRL;
                    `CPU_FN_SRA:  decodedOp = ALU_SRA;
                    default:      decodedOp = ALU_PASS;
                endcase
            end
            `CPU_OP_ADDIU, `CPU_OP_LW, `CPU_OP_SW: decodedOp = ALU_ADD;
            `CPU_OP_SLTI:  decodedOp = ALU_SLT;
            `CPU_OP_SLTIU: decodedOp = ALU_SLTU;
            `CPU_OP_ANDI:  decodedOp = ALU_AND;
            `CPU_OP_ORI:   decodedOp = ALU_OR;
            `CPU_OP_XORI:  decodedOp = ALU_XOR;
            `CPU_OP_LUI:   decodedOp = ALU_LUI;
            default:       decodedOp = ALU_PASS;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= S_FETCH;
            pc          <= `CPU_RESET_VECTOR;
            redirect    <= 1'b0;
            fetchIssued <= 1'b0;
            memIssued   <= 1'b0;
        end else begin
            case (state)
                S_FETCH: begin
                    if (pc == '0) begin
                        state <= S_HALT;
                    end else if (instrValid) begin
                        fetchIssued <= 1'b0;
                        // Delay slot done fetching, so take the pending target now
                        pc          <= redirect ? target : pc + 32'd4;
                        redirect    <= 1'b0;
                        state       <= S_DECODE;
                    end else if (fetchValid && fetchReady) begin
                        fetchIssued <= 1'b1;
                    end
                end
                S_DECODE: state <= S_EXECUTE;
                S_EXECUTE: begin
                    if (isLoad || isStore) begin
                        state <= S_MEMORY;
                    end else if (isJump || takeBranch) begin
                        redirect <= 1'b1;
                        state    <= S_FETCH;
                    end else if (isBranch) begin
                        state <= S_FETCH;
                    end else begin
                        state <= S_WRITEBACK;
                    end
                end
                S_MEMORY: begin
                    if (memDone) begin
                        memIssued <= 1'b0;
                        state     <= isLoad ? S_WRITEBACK : S_FETCH;
                    end else if (memValid && memReady) begin
                        memIssued <= 1'b1;
                    end
                end
                S_WRITEBACK: state <= S_FETCH;
                S_HALT:      state <= S_HALT;
                default:     state <= S_FETCH;
            endcase
        end
    end

    // Instruction, decoded fields and memory request payload
    always_ff @(posedge clk) begin
        if ((state == S_FETCH) && instrValid) begin
            ir <= instr;
        end
        if (state == S_DECODE) begin
            aluOp  <= decodedOp;
            useImm <= !isBranch && (opcode != `CPU_OP_SPECIAL);
            immExt <= zeroExtImm ? {16'h0000, ir[15:0]} : {{16{ir[15]}}, ir[15:0]};
        end
        if (state == S_EXECUTE) begin
            memAddress   <= aluResult;
            memWrite     <= isStore;
            memWriteData <= readDataB;
            if (opcode == `CPU_OP_SPECIAL) begin
                target <= readDataA;
            end else if (opcode == `CPU_OP_J) begin
                target <= {pc[31:28], ir[25:0], 2'b00};
            end else begin
                // pc already points at the delay slot
                target <= pc + {immExt[29:0], 2'b00};
            end
        end
    end

    // Units answer only a request that is still outstanding
    assert property (@(posedge clk) disable iff (reset)
        instrValid |-> ((state == S_FETCH) && fetchIssued));

    assert property (@(posedge clk) disable iff (reset)
        memDone |-> ((state == S_MEMORY) && memIssued));

endmodule

/* design/cpuPkg.sv */
`include "cpu_consts.svh"

package cpuPkg;

    typedef logic [`CPU_WORD_WIDTH-1:0] word_t;
    typedef logic [$clog2(`CPU_REG_COUNT)-1:0] regAddr_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI,
        ALU_PASS
    } aluOp_t;

    typedef enum logic [2:0] {
        S_FETCH,
        S_DECODE,
        S_EXECUTE,
        S_MEMORY,
        S_WRITEBACK,
        S_HALT
    } cpuState_t;

    // Bus words arrive with their byte order reversed
    function automatic word_t byteSwap(input word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

endpackage

/* design/cpu_consts.svh */
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// First instruction address after reset
`define CPU_RESET_VECTOR 32'hBFC00000

`define CPU_WORD_WIDTH 32
`define CPU_REG_COUNT  32

// Primary opcodes, instruction bits 31:26
`define CPU_OP_SPECIAL 6'd0
`define CPU_OP_J       6'd2
`define CPU_OP_BEQ     6'd4
`define CPU_OP_BNE     6'd5
`define CPU_OP_ADDIU   6'd9
`define CPU_OP_SLTI    6'd10
`define CPU_OP_SLTIU   6'd11
`define CPU_OP_ANDI    6'd12
`define CPU_OP_ORI     6'd13
`define CPU_OP_XORI    6'd14
`define CPU_OP_LUI     6'd15
`define CPU_OP_LW      6'd35
`define CPU_OP_SW      6'd43

// Function codes for SPECIAL, instruction bits 5:0
`define CPU_FN_SLL  6'd0
`define CPU_FN_SRL  6'd2
`define CPU_FN_SRA  6'd3
`define CPU_FN_JR   6'd8
`define CPU_FN_ADDU 6'd33
`define CPU_FN_SUBU 6'd35
`define CPU_FN_AND  6'd36
`define CPU_FN_OR   6'd37
`define CPU_FN_XOR  6'd38
`define CPU_FN_SLT  6'd42
`define CPU_FN_SLTU 6'd43

`endif

/* design/fetchUnit.sv */
`timescale 1ns/10ps

module fetchUnit import cpuPkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  fetchValid,
    input  word_t fetchAddress,
    input  logic  busReady,
    input  word_t readdata,
    output logic  fetchReady,
    output logic  busReqValid,
    output word_t busReqAddress,
    output logic  instrValid,
    output word_t instr
);

    logic pending;

    // One fetch in flight at a time
    assign fetchReady  = !pending;
    assign busReqValid = pending;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending    <= 1'b0;
            instrValid <= 1'b0;
        end else begin
            instrValid <= pending && busReady;
            if (fetchValid && fetchReady) begin
                pending <= 1'b1;
            end else if (busReady) begin
                pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetchValid && fetchReady) begin
            busReqAddress <= fetchAddress;
        end
        // Capture in the completing bus cycle
        if (pending && busReady) begin
            instr <= byteSwap(readdata);
        end
    end

endmodule

/* design/loadStoreUnit.sv */
`timescale 1ns/10ps

module loadStoreUnit import cpuPkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  memValid,
    input  logic  memWrite,
    input  word_t memAddress,
    input  word_t memWriteData,
    input  logic  busReady,
    input  word_t readdata,
    output logic  memReady,
    output logic  busReqValid,
    output logic  busReqWrite,
    output word_t busReqAddress,
    output word_t busReqWriteData,
    output logic  memDone,
    output word_t memReadData
);

    logic pending;

    assign memReady    = !pending;
    assign busReqValid = pending;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
            memDone <= 1'b0;
        end else begin
            memDone <= pending && busReady;
            if (memValid && memReady) begin
                pending <= 1'b1;
            end else if (busReady) begin
                pending <= 1'b0;
            end
        end
    end

    // Request payload, store data already in bus byte order
    always_ff @(posedge clk) begin
        if (memValid && memReady) begin
            busReqWrite     <= memWrite;
            busReqAddress   <= memAddress;
            busReqWriteData <= byteSwap(memWriteData);
        end
        if (pending && busReady && !busReqWrite) begin
            memReadData <= byteSwap(readdata);
        end
    end

    // No new request while one is still outstanding
    assert property (@(posedge clk) disable iff (reset)
        pending |-> !memValid);

endmodule

/* design/mipsCpuBus.sv */
`timescale 1ns/10ps

module mipsCpuBus import cpuPkg::*; (
    input  logic       clk,
    input  logic       reset,
    output logic       active,
    output word_t      register_v0,
    output word_t      address,
    output logic       write,
    output logic       read,
    input  logic       waitrequest,
    output word_t      writedata,
    output logic [3:0] byteenable,
    input  word_t      readdata
);

    // Sequencer to fetch and load/store units
    logic       fetchValid;
    logic       fetchReady;
    word_t      fetchAddress;
    logic       instrValid;
    word_t      instr;
    logic       memValid;
    logic       memReady;
    logic       memWrite;
    word_t      memAddress;
    word_t      memWriteData;
    logic       memDone;
    word_t      memReadData;

    // Requesters to arbiter
    logic       fetchReqValid;
    logic       fetchReqReady;
    word_t      fetchReqAddress;
    logic       lsuReqValid;
    logic       lsuReqReady;
    logic       lsuReqWrite;
    word_t      lsuReqAddress;
    word_t      lsuReqWriteData;

    // Datapath
    regAddr_t   readAddrA;
    regAddr_t   readAddrB;
    word_t      readDataA;
    word_t      readDataB;
    logic       regWriteEnable;
    regAddr_t   regWriteAddr;
    word_t      regWriteData;
    aluOp_t     aluOp;
    word_t      aluOperandA;
    word_t      aluOperandB;
    logic [4:0] aluShift;
    word_t      aluResult;
    logic       aluEqual;

    cpuControl i_control (.*);

    fetchUnit i_fetch (
        .busReady      (fetchReqReady),
        .busReqValid   (fetchReqValid),
        .busReqAddress (fetchReqAddress),
        .*
    );

    loadStoreUnit i_lsu (
        .busReady        (lsuReqReady),
        .busReqValid     (lsuReqValid),
        .busReqWrite     (lsuReqWrite),
        .busReqAddress   (lsuReqAddress),
        .busReqWriteData (lsuReqWriteData),
        .*
    );

    busArbiter i_arbiter (.*);

    registerFile i_regs (
        .writeEnable (regWriteEnable),
        .writeAddr   (regWriteAddr),
        .writeData   (regWriteData),
        .registerV0  (register_v0),
        .*
    );

    alu i_alu (
        .op          (aluOp),
        .operandA    (aluOperandA),
        .operandB    (aluOperandB),
        .shiftAmount (aluShift),
        .result      (aluResult),
        .equal       (aluEqual)
    );

endmodule

/* design/registerFile.sv */
`timescale 1ns/10ps
`include "cpu_consts.svh"

module registerFile import cpuPkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  regAddr_t readAddrA,
    input  regAddr_t readAddrB,
    input  logic     writeEnable,
    input  regAddr_t writeAddr,
    input  word_t    writeData,
    output word_t    readDataA,
    output word_t    readDataB,
    output word_t    registerV0
);

    word_t regs [`CPU_REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && (writeAddr != '0)) begin
            // $zero is never written, so it stays at its reset value
            regs[writeAddr] <= writeData;
        end
    end

    assign readDataA  = regs[readAddrA];
    assign readDataB  = regs[readAddrB];
    assign registerV0 = regs[2];

endmodule

/* sources.f */
+incdir+design
design/cpuPkg.sv
design/alu.sv
design/registerFile.sv
design/busArbiter.sv
design/fetchUnit.sv
design/loadStoreUnit.sv
design/cpuControl.sv
design/mipsCpuBus.sv
test/clockGen.sv
test/tbMipsCpu.sv

/* test/clockGen.sv */
`timescale 1ns/10ps

module clockGen (
    output logic clk,
    output logic reset,
    input  logic resetRequest
);

    logic [2:0] cyclesLeft;
    logic       requested;

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        // Startup reset already covers the first edge
        cyclesLeft = 3'd3;
    end

    always #5 clk = ~clk;

    // Reset moves 1 ns after the rising edge, four edges per request
    always @(posedge clk) begin
        requested = resetRequest;
        #1;
        if (requested) begin
            cyclesLeft = 3'd4;
        end
        reset = cyclesLeft != 3'd0;
        if (cyclesLeft != 3'd0) begin
            cyclesLeft = cyclesLeft - 3'd1;
        end
    end

endmodule

/* test/tbMipsCpu.sv */
`timescale 1ns/10ps

module tbMipsCpu import cpuPkg::*; ();

    localparam word_t ROM_BASE    = 32'hBFC00000;
    localparam word_t DATA_BASE   = 32'h00001000;
    localparam int    MEM_WORDS   = 64;
    localparam int    RESET_LIMIT = 20;
    localparam int    READ_LIMIT  = 50;
    localparam int    HALT_LIMIT  = 5000;

    logic       clk;
    logic       reset;
    logic       resetRequest;
    logic       active;
    word_t      registerV0;
    word_t      address;
    logic       read;
    logic       write;
    logic       waitrequest;
    word_t      writedata;
    logic [3:0] byteenable;
    word_t      readdata;

    integer     seed;
    logic       stallMode;
    word_t      romMem [MEM_WORDS];
    word_t      dataMem [MEM_WORDS];
    int         errorCount;
    int         checkCount;
    int         timeoutCount;
    logic       readSeen;
    word_t      firstReadAddress;
    logic [3:0] firstReadEnable;
    word_t      writeCount;
    word_t      lastWriteAddress;
    word_t      lastWriteData;

    clockGen i_clock (
        .clk          (clk),
        .reset        (reset),
        .resetRequest (resetRequest)
    );

    mipsCpuBus i_dut (
        .clk         (clk),
        .reset       (reset),
        .active      (active),
        .register_v0 (registerV0),
        .address     (address),
        .write       (write),
        .read        (read),
        .waitrequest (waitrequest),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata)
    );

    // Byte i of the result is byte 3-i of the input
    function automatic word_t swapBytes(input word_t w);
        word_t swapped;
        for (int i = 0; i < 4; i++) begin
            swapped[8*i +: 8] = w[8*(3-i) +: 8];
        end
        return swapped;
    endfunction

    function automatic word_t fillPattern(input word_t addr);
        return addr ^ 32'h5A5AC3C3;
    endfunction

    function automatic logic inRom(input word_t addr);
        return addr[31:8] == ROM_BASE[31:8];
    endfunction

    function automatic logic inData(input word_t addr);
        return addr[31:8] == DATA_BASE[31:8];
    endfunction

    function automatic word_t memRead(input word_t addr);
        if (inRom(addr)) begin
            return romMem[addr[7:2]];
        end else if (inData(addr)) begin
            return dataMem[addr[7:2]];
        end
        return 32'h0;
    endfunction

    // Memory answers in the same cycle, stalls only in back-pressure runs
    always @(posedge clk) begin
        #1;
        waitrequest = stallMode && (($random(seed) & 1) != 0);
        readdata    = swapBytes(memRead(address));
    end

    // Bus monitor at the falling edge
    always @(negedge clk) begin
        if (reset) begin
            readSeen   = 1'b0;
            writeCount = '0;
        end else begin
            if (read && write) begin
                errorCount++;
                $display("Error at %0t: read and write were high in the same cycle", $time);
            end
            if (read && !readSeen) begin
                readSeen         = 1'b1;
                firstReadAddress = address;
                firstReadEnable  = byteenable;
            end
            if ((read || write) && !waitrequest && !inRom(address) && !inData(address)) begin
                errorCount++;
                $display("Error at %0t: bus access to unmapped address %h", $time, address);
            end
            if (write && !waitrequest) begin
                writeCount++;
                lastWriteAddress = address;
                lastWriteData    = writedata;
                if (inData(address)) begin
                    dataMem[address[7:2]] = swapBytes(writedata);
                end
            end
        end
    end

    task automatic checkWord(input string name, input word_t actual, input word_t expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("FAILED at %0t: %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic checkBit(input string name, input logic actual, input logic expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("FAILED at %0t: %s expected %b got %b", $time, name, expected, actual);
        end
    endtask

    task automatic checkLanes(input string name, input logic [3:0] actual,
                              input logic [3:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("FAILED at %0t: %s expected %b got %b", $time, name, expected, actual);
        end
    endtask

    task automatic loadProgram(input word_t image [$]);
        for (int i = 0; i < MEM_WORDS; i++) begin
            romMem[i]  = fillPattern(ROM_BASE + 4 * i);
            dataMem[i] = fillPattern(DATA_BASE + 4 * i);
        end
        foreach (image[i]) begin
            romMem[i] = image[i];
        end
    endtask

    // Returns at the first falling edge with reset low
    task automatic applyReset(input logic stall);
        int cycles;
        @(negedge clk);
        stallMode = stall;
        @(posedge clk);
        #1;
        resetRequest = 1'b1;
        @(posedge clk);
        #1;
        resetRequest = 1'b0;
        cycles = 0;
        @(negedge clk);
        while (reset && cycles < RESET_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (reset) begin
            timeoutCount++;
            $display("Timeout at %0t: reset was never released", $time);
        end
    endtask

    task automatic waitHalt(input string testName);
        int cycles;
        cycles = 0;
        while (active && cycles < HALT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (active) begin
            timeoutCount++;
            $display("Timeout at %0t: %s did not halt within %0d cycles",
                     $time, testName, HALT_LIMIT);
        end
    endtask

    task automatic runProgram(input word_t image [$], input logic stall, input string name);
        loadProgram(image);
        applyReset(stall);
        waitHalt(name);
    endtask

    task automatic testReset();
        word_t image [$];
        int    cycles;
        // jr $0, nop
        image = '{32'h00000008, 32'h00000000};
        loadProgram(image);
        applyReset(1'b0);
        checkBit("active", active, 1'b1);
        checkBit("write", write, 1'b0);
        checkBit("read", read, 1'b0);
        checkWord("register_v0", registerV0, 32'h0);
        cycles = 0;
        while (!readSeen && cycles < READ_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!readSeen) begin
            timeoutCount++;
            $display("Timeout at %0t: no instruction read after reset", $time);
        end else begin
            checkWord("address", firstReadAddress, ROM_BASE);
            checkLanes("byteenable", firstReadEnable, 4'b1111);
        end
        waitHalt("reset test");
    endtask

    task automatic testAlu(input logic stall);
        word_t image [$];
        word_t r [32];
        // addiu $8,0x1234 / lui $9 / ori $9 / andi $10 / xori $11 / addu $12 / subu $13
        image = '{32'h24081234, 32'h3C098765, 32'h3529F0F0, 32'h312AFF00,
                  32'h390BFFFF, 32'h01286021, 32'h01096823,
                  // and $14 / or $15 / xor $16 / slt $17 / sltu $18 / sll / srl / sra
                  32'h012C7024, 32'h014B7825, 32'h01AE8026, 32'h0128882A,
                  32'h0109902B, 32'h000F9900, 32'h0010A202, 32'h0009AB03,
                  // fold into $2, then jr $0 with addiu $2 in the delay slot
                  32'h018E1021, 32'h00501026, 32'h00511021, 32'h00521021,
                  32'h00531026, 32'h00541023, 32'h00551026, 32'h004F1025,
                  32'h00000008, 32'h24420101, 32'h24420001};
        runProgram(image, stall, "ALU test");
        r[8]  = 32'h00001234;
        r[9]  = 32'h87650000 | 32'h0000F0F0;
        r[10] = r[9] & 32'h0000FF00;
        r[11] = r[8] ^ 32'h0000FFFF;
        r[12] = r[9] + r[8];
        r[13] = r[8] - r[9];
        r[14] = r[9] & r[12];
        r[15] = r[10] | r[11];
        r[16] = r[13] ^ r[14];
        r[17] = ($signed(r[9]) < $signed(r[8])) ? 32'd1 : 32'd0;
        r[18] = (r[8] < r[9]) ? 32'd1 : 32'd0;
        r[19] = r[15] << 4;
        r[20] = r[16] >> 8;
        // Arithmetic shift by 12 copies the sign bit into the top
        r[21] = {{12{r[9][31]}}, r[9][31:12]};
        r[2]  = (((r[12] + r[14]) ^ r[16]) + r[17] + r[18]) ^ r[19];
        r[2]  = ((r[2] - r[20]) ^ r[21]) | r[15];
        r[2]  = r[2] + 32'h00000101;
        checkWord("register_v0", registerV0, r[2]);
        checkBit("active", active, 1'b0);
    endtask

    task automatic testLoadStore(input logic stall);
        word_t image [$];
        // addiu $8,0x1000 / lui+ori $9 / sw $9,8($8) / lw $2,8($8) / jr $0 / nop
        image = '{32'h24081000, 32'h3C09CAFE, 32'h3529B0BA, 32'hAD090008,
                  32'h8D020008, 32'h00000008, 32'h00000000};
        runProgram(image, stall, "load/store test");
        checkWord("bus write count", writeCount, 32'd1);
        checkWord("address", lastWriteAddress, DATA_BASE + 32'd8);
        checkWord("writedata", lastWriteData, swapBytes(32'hCAFEB0BA));
        checkWord("stored word", dataMem[2], 32'hCAFEB0BA);
        checkWord("register_v0", registerV0, 32'hCAFEB0BA);
        checkBit("active", active, 1'b0);
    endtask

    task automatic testBranches(input logic stall);
        word_t image [$];
        // $2 = 0, $8 = $9 = 5, beq taken over +0x100
        image = '{32'h24020000, 32'h24080005, 32'h24090005, 32'h11090002,
                  32'h24420001, 32'h24420100,
                  // bne not taken, so +4 runs after its delay slot
                  32'h15090003, 32'h24420002, 32'h24420004,
                  // j over +0x200, jr $0 with +0x10 in the delay slot
                  32'h0BF0000C, 32'h24420008, 32'h24420200,
                  32'h00000008, 32'h24420010, 32'h24420400};
        runProgram(image, stall, "branch test");
        // Delay slots and the fall-through only
        checkWord("register_v0", registerV0, 32'h1 + 32'h2 + 32'h4 + 32'h8 + 32'h10);
        checkBit("active", active, 1'b0);
    endtask

    task automatic testRegisterZero();
        word_t image [$];
        // addiu $0 / lui $0 / addiu $2,$0,0x77 / addu $2,$2,$0 / jr $0 / nop
        image = '{32'h24000055, 32'h3C001234, 32'h24020077, 32'h00401021,
                  32'h00000008, 32'h00000000};
        runProgram(image, 1'b0, "register zero test");
        checkWord("register_v0", registerV0, 32'h00000077);
        checkBit("active", active, 1'b0);
    endtask

    initial begin
        seed             = 32'h89ace482;
        stallMode        = 1'b0;
        resetRequest     = 1'b0;
        waitrequest      = 1'b0;
        readdata         = '0;
        errorCount       = 0;
        checkCount       = 0;
        timeoutCount     = 0;
        readSeen         = 1'b0;
        writeCount       = '0;
        lastWriteAddress = '0;
        lastWriteData    = '0;
        testReset();
        testAlu(1'b0);
        testLoadStore(1'b0);
        testBranches(1'b0);
        testRegisterZero();
        // Same programs again under random waitrequest
        testAlu(1'b1);
        testLoadStore(1'b1);
        testBranches(1'b1);
        $display("Checks: %0d, errors: %0d, timeouts: %0d", checkCount, errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
